// ==== dv/host_mem_vtp_tb.sv ====
/*
 * Directed testbench for the two-source translation subsystem.
 * MMIO writes happen only while both sources are idle, so the model never races the DUT.
 */
`timescale 1ns/1ns
`include "vtp_settings.svh"

module host_mem_vtp_tb
    import vtp_pkg::*;
;

    // One outcome expected from a source as either an err or a host request
    typedef struct packed {
        src_id_t  src;
        logic     is_err;
        mem_req_t req;
    } expect_t;

    logic                        clk;
    logic                        rst_n;
    logic                        mmio_wr;
    logic [pt_idx_w-1:0]         mmio_index;
    pt_entry_t                   mmio_entry;
    logic [`VTP_NUM_SOURCES-1:0] req_valid;
    va_req_t                     req [`VTP_NUM_SOURCES];
    logic [`VTP_NUM_SOURCES-1:0] busy;
    logic [`VTP_NUM_SOURCES-1:0] err;
    logic                        host_req_valid;
    mem_req_t                    host_req;
    src_id_t                     host_req_src;

    // Reference page table written by the same task that drives MMIO
    logic             model_valid [`VTP_PT_ENTRIES];
    logic [ppn_w-1:0] model_ppn [`VTP_PT_ENTRIES];

    expect_t     exp_q [$];
    string       test_name;
    int          value_errors;
    int          other_errors;
    int          timeouts;
    logic [31:0] rng;

    host_mem_vtp i_host_mem_vtp (
        .clk            (clk),
        .rst_n          (rst_n),
        .mmio_wr        (mmio_wr),
        .mmio_index     (mmio_index),
        .mmio_entry     (mmio_entry),
        .req_valid      (req_valid),
        .req            (req),
        .busy           (busy),
        .err            (err),
        .host_req_valid (host_req_valid),
        .host_req       (host_req),
        .host_req_src   (host_req_src)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ==================================================================
    // Helpers
    // ==================================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // A known page gives {ppn, offset} and any other page errs
    function automatic expect_t predict(input int src, input va_req_t r);
        expect_t          e;
        logic [vpn_w-1:0] vpn;
        vpn   = r.addr[`VTP_VA_WIDTH-1:`VTP_PAGE_BITS];
        e     = '0;
        e.src = src_id_t'(src);
        if (vpn >= `VTP_PT_ENTRIES || !model_valid[vpn[pt_idx_w-1:0]]) begin
            e.is_err = 1'b1;
        end else begin
            e.req.wr   = r.wr;
            e.req.addr = {model_ppn[vpn[pt_idx_w-1:0]], r.addr[`VTP_PAGE_BITS-1:0]};
            e.req.data = r.data;
        end
        return e;
    endfunction

    // Moves to 1 ns after the next rising edge and drops all strobes
    task automatic tick();
        @(posedge clk);
        #1;
        req_valid = '0;
        mmio_wr   = 1'b0;
    endtask

    task automatic write_entry(input int idx, input logic valid, input logic [ppn_w-1:0] ppn);
        mmio_wr          = 1'b1;
        mmio_index       = pt_idx_w'(idx);
        mmio_entry.valid = valid;
        mmio_entry.ppn   = ppn;
        model_valid[idx] = valid;
        model_ppn[idx]   = ppn;
        tick();
    endtask

    // Strobes one request in the current cycle; caller has checked busy
    task automatic drive_req(input int src, input logic wr, input logic [31:0] addr,
                             input logic [63:0] data);
        va_req_t r;
        r.wr           = wr;
        r.addr         = addr;
        r.data         = data;
        req[src]       = r;
        req_valid[src] = 1'b1;
        exp_q.push_back(predict(src, r));
    endtask

    task automatic wait_idle(input int src);
        int n;
        n = 0;
        while (busy[src] && n < 50) begin
            tick();
            n++;
        end
        assert (!busy[src]) else begin
            timeouts++;
            $display("Timeout in %s: source %0d stayed busy for 50 cycles", test_name, src);
        end
    endtask

    // Waits until every expected outcome has been seen, then idles to catch extras
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 50) begin
            tick();
            n++;
        end
        assert (exp_q.size() == 0) else begin
            timeouts++;
            $display("Timeout in %s: %0d expected results never arrived",
                     test_name, exp_q.size());
            exp_q.delete();
        end
        repeat (4) tick();
    endtask

    // Matches an observed outcome against the oldest one expected from that source
    task automatic check_arrival(input int src, input logic is_err, input mem_req_t act);
        int      idx;
        expect_t e;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i].src == src_id_t'(src)) begin
                idx = i;
            end
        end
        assert (idx >= 0) else begin
            other_errors++;
            $display("Unexpected %s on source %0d in %s with nothing outstanding",
                     is_err ? "err pulse" : "host request", src, test_name);
        end
        if (idx >= 0) begin
            e = exp_q[idx];
            exp_q.delete(idx);
            assert (e.is_err == is_err) else begin
                value_errors++;
                $display("ERROR %s: source %0d expected %s, actual %s", test_name, src,
                         e.is_err ? "err" : "host request", is_err ? "err" : "host request");
            end
            if (!e.is_err && !is_err) begin
                assert (e.req == act) else begin
                    value_errors++;
                    $display("ERROR %s: src %0d expected wr/addr/data %b/%h/%h, actual %b/%h/%h",
                             test_name, src, e.req.wr, e.req.addr, e.req.data,
                             act.wr, act.addr, act.data);
                end
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (host_req_valid) begin
                check_arrival(int'(host_req_src), 1'b0, host_req);
            end
            for (int s = 0; s < `VTP_NUM_SOURCES; s++) begin
                if (err[s]) begin
                    check_arrival(s, 1'b1, '0);
                end
            end
        end
    end

    // ==================================================================
    // Tests
    // ==================================================================

    task automatic test_reset();
        test_name = "reset";
        for (int n = 0; n < 10; n++) begin
            assert (busy == '0 && err == '0 && !host_req_valid) else begin
                value_errors++;
                $display("ERROR %s: expected busy/err/host_req_valid 0/0/0, actual %b/%b/%b",
                         test_name, busy, err, host_req_valid);
            end
            tick();
        end
    endtask

    task automatic test_mapped();
        test_name = "mapped";
        for (int i = 0; i < 4; i++) begin
            write_entry(i, 1'b1, ppn_w'(32'hA0000 + i * 32'h111));
        end
        // Read then write from each source
        wait_idle(0);
        drive_req(0, 1'b0, 32'h0000_1234, 64'h0);
        tick();
        wait_idle(0);
        drive_req(0, 1'b1, 32'h0000_2ff8, 64'hDEAD_BEEF_0123_4567);
        tick();
        wait_idle(1);
        drive_req(1, 1'b0, 32'h0000_3010, 64'h0);
        tick();
        wait_idle(1);
        drive_req(1, 1'b1, 32'h0000_0abc, 64'h0F0F_1234_5678_9ABC);
        tick();
        wait_drain();
    endtask

    task automatic test_fault();
        test_name = "fault";
        write_entry(7, 1'b0, ppn_w'(32'h77777));
        wait_idle(0);
        drive_req(0, 1'b1, 32'h0000_7444, 64'h1111_2222_3333_4444);
        tick();
        wait_drain();
        // Page number 16 lies just past the table
        wait_idle(1);
        drive_req(1, 1'b0, 32'h0001_0abc, 64'h0);
        tick();
        wait_drain();
    endtask

    task automatic test_contention();
        test_name = "contention";
        write_entry(8, 1'b1, ppn_w'(32'h80808));
        write_entry(9, 1'b1, ppn_w'(32'h90909));
        wait_idle(0);
        wait_idle(1);
        drive_req(0, 1'b1, 32'h0000_8100, 64'hAAAA_0000_0000_0001);
        drive_req(1, 1'b1, 32'h0000_9200, 64'hBBBB_0000_0000_0002);
        tick();
        wait_drain();
    endtask

    task automatic test_remap();
        test_name = "remap";
        write_entry(5, 1'b1, ppn_w'(32'h12345));
        wait_idle(1);
        drive_req(1, 1'b0, 32'h0000_5678, 64'h0);
        tick();
        wait_drain();
        write_entry(5, 1'b1, ppn_w'(32'h54321));
        wait_idle(1);
        drive_req(1, 1'b0, 32'h0000_5678, 64'h0);
        tick();
        wait_drain();
    endtask

    task automatic test_random();
        int          src;
        logic [31:0] page;
        logic [31:0] addr;
        logic [63:0] data;
        test_name = "random";
        // Roughly three of four entries are mapped and pages up to 19 reach past the table
        for (int i = 0; i < `VTP_PT_ENTRIES; i++) begin
            rng = xorshift(rng);
            write_entry(i, rng[1:0] != 2'b00, ppn_w'(rng >> 8));
        end
        for (int n = 0; n < 40; n++) begin
            rng  = xorshift(rng);
            src  = int'(rng[0]);
            page = (rng >> 4) % 20;
            rng  = xorshift(rng);
            addr = (page << `VTP_PAGE_BITS) | (rng & 32'hFFF);
            data[63:32] = rng;
            rng  = xorshift(rng);
            data[31:0] = rng;
            wait_idle(src);
            drive_req(src, rng[7], addr, data);
            tick();
        end
        wait_drain();
    endtask

    // ==================================================================
    // Sequence
    // ==================================================================

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        mmio_wr      = 1'b0;
        mmio_index   = '0;
        mmio_entry   = '0;
        req_valid    = '0;
        value_errors = 0;
        other_errors = 0;
        timeouts     = 0;
        rng          = 32'd14;
        test_name    = "init";
        for (int s = 0; s < `VTP_NUM_SOURCES; s++) begin
            req[s] = '0;
        end
        for (int i = 0; i < `VTP_PT_ENTRIES; i++) begin
            model_valid[i] = 1'b0;
            model_ppn[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset();
        test_mapped();
        test_fault();
        test_contention();
        test_remap();
        test_random();

        $display("Summary: %0d value errors, %0d other errors, %0d timeouts",
                 value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== include/vtp_settings.svh ====
/*
 * Build-time sizing for the address translation subsystem. Widths must keep
 * VTP_PA_WIDTH - VTP_PAGE_BITS equal to the page number width in the package.
 */
`ifndef VTP_SETTINGS_SVH
`define VTP_SETTINGS_SVH

// Virtual address width seen by the request sources
`define VTP_VA_WIDTH 32

// Physical address width driven onto the host port
`define VTP_PA_WIDTH 32

// Offset bits inside one page, passed through untranslated
`define VTP_PAGE_BITS 12

// Depth of the single-level page table
`define VTP_PT_ENTRIES 16

// Request sources, DMA engine first and kernel second
`define VTP_NUM_SOURCES 2

// Write data carried alongside each request
`define VTP_DATA_WIDTH 64

`endif

// ==== rtl/host_mem_vtp.sv ====
/*
 * Two translated sources sharing one page table and one host memory port.
 * The host port has no back-pressure; read data and responses route by host_req_src.
 */
`timescale 1ns/1ns
`include "vtp_settings.svh"

module host_mem_vtp
    import vtp_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mmio_wr,
    input  logic [pt_idx_w-1:0]           mmio_index,
    input  pt_entry_t                     mmio_entry,
    input  logic [`VTP_NUM_SOURCES-1:0]   req_valid,
    input  va_req_t                       req [`VTP_NUM_SOURCES],
    output logic [`VTP_NUM_SOURCES-1:0]   busy,
    output logic [`VTP_NUM_SOURCES-1:0]   err,
    output logic                          host_req_valid,
    output mem_req_t                      host_req,
    output src_id_t                       host_req_src
);

    // Lookup side, translators to page table
    logic [`VTP_NUM_SOURCES-1:0] lk_valid;
    pt_lookup_t                  lk_req [`VTP_NUM_SOURCES];
    logic                        lk_grant_valid;
    src_id_t                     lk_grant_src;
    pt_lookup_t                  lk_grant;

    // Page table answer, strobe per source and shared payload
    logic [`VTP_NUM_SOURCES-1:0] rsp_valid;
    pt_entry_t                   rsp_entry;
    logic                        rsp_hit;

    // Memory side, translators to host port
    logic [`VTP_NUM_SOURCES-1:0] out_valid;
    mem_req_t                    out_req [`VTP_NUM_SOURCES];

    // ==================================================================
    // One translator per source, index 0 is the DMA engine
    // ==================================================================

    for (genvar s = 0; s < `VTP_NUM_SOURCES; s++) begin : g_src
        vtp_translate i_translate (
            .clk          (clk),
            .rst_n        (rst_n),
            .req_valid    (req_valid[s]),
            .req          (req[s]),
            .busy         (busy[s]),
            .lookup_valid (lk_valid[s]),
            .lookup       (lk_req[s]),
            .rsp_valid    (rsp_valid[s]),
            .rsp_entry    (rsp_entry),
            .rsp_hit      (rsp_hit),
            .out_valid    (out_valid[s]),
            .out_req      (out_req[s]),
            .err          (err[s])
        );
    end

    // ==================================================================
    // Shared page table behind the lookup arbiter
    // ==================================================================

    vtp_rr_arbiter #(.payload_t(pt_lookup_t)) i_lookup_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (lk_valid),
        .in_payload    (lk_req),
        .grant_valid   (lk_grant_valid),
        .grant_src     (lk_grant_src),
        .grant_payload (lk_grant)
    );

    vtp_page_table i_page_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr      (mmio_wr),
        .mmio_index   (mmio_index),
        .mmio_entry   (mmio_entry),
        .lookup_valid (lk_grant_valid),
        .lookup       (lk_grant),
        .lookup_src   (lk_grant_src),
        .rsp_valid    (rsp_valid),
        .rsp_entry    (rsp_entry),
        .rsp_hit      (rsp_hit)
    );

    // Translated requests merge onto the single host port
    vtp_rr_arbiter #(.payload_t(mem_req_t)) i_mem_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (out_valid),
        .in_payload    (out_req),
        .grant_valid   (host_req_valid),
        .grant_src     (host_req_src),
        .grant_payload (host_req)
    );

endmodule

// ==== rtl/vtp_page_table.sv ====
/*
 * Single-level page table, written only through MMIO strobes.
 * Lookups answer one cycle later; a write lands before any later lookup.
 */
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_page_table
    import vtp_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mmio_wr,
    input  logic [pt_idx_w-1:0]           mmio_index,
    input  pt_entry_t                     mmio_entry,
    input  logic                          lookup_valid,
    input  pt_lookup_t                    lookup,
    input  src_id_t                       lookup_src,
    output logic [`VTP_NUM_SOURCES-1:0]   rsp_valid,
    output pt_entry_t                     rsp_entry,
    output logic                          rsp_hit
);

    pt_entry_t            table_q [`VTP_PT_ENTRIES];
    logic                 in_range;
    logic [pt_idx_w-1:0]  rd_index;
    pt_entry_t            rd_entry;

    // ==================================================================
    // Table storage
    // ==================================================================

    // Entries start invalid so nothing translates before software fills them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `VTP_PT_ENTRIES; i++) begin
                table_q[i] <= '0;
            end
        end else if (mmio_wr) begin
            table_q[mmio_index] <= mmio_entry;
        end
    end

    // ==================================================================
    // Lookup
    // ==================================================================

    // Page numbers past the table depth are a miss, never an alias
    assign in_range = lookup.vpn < vpn_w'(`VTP_PT_ENTRIES);
    assign rd_index = lookup.vpn[pt_idx_w-1:0];
    assign rd_entry = table_q[rd_index];

    // Response strobe is one-hot on the requesting source
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= '0;
        end else begin
            rsp_valid <= '0;
            if (lookup_valid) begin
                rsp_valid[lookup_src] <= 1'b1;
            end
        end
    end

    // Entry and hit flag are only meaningful alongside rsp_valid
    always_ff @(posedge clk) begin
        rsp_entry <= rd_entry;
        rsp_hit   <= in_range && rd_entry.valid;
    end

    // Software must keep its index inside the table
    a_mmio_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        mmio_wr |-> (int'(mmio_index) < `VTP_PT_ENTRIES));

endmodule

// ==== rtl/vtp_pkg.sv ====
/*
 * Shared request, lookup and page table entry types.
 * The source id is at least one bit wide even with a single source.
 */
`include "vtp_settings.svh"

package vtp_pkg;

    // Virtual page number width, the part of the address that is translated
    localparam int vpn_w = `VTP_VA_WIDTH - `VTP_PAGE_BITS;

    // Physical page number width held in each table entry
    localparam int ppn_w = `VTP_PA_WIDTH - `VTP_PAGE_BITS;

    // Table index width follows from the entry count
    localparam int pt_idx_w = $clog2(`VTP_PT_ENTRIES);

    // Source id width, never allowed to collapse to zero bits
    localparam int src_w = (`VTP_NUM_SOURCES > 1) ? $clog2(`VTP_NUM_SOURCES) : 1;

    typedef logic [src_w-1:0] src_id_t;

    // Request as issued by a source, before translation
    typedef struct packed {
        logic                       wr;
        logic [`VTP_VA_WIDTH-1:0]   addr;
        logic [`VTP_DATA_WIDTH-1:0] data;
    } va_req_t;

    // Same request after translation, addr now physical
    typedef struct packed {
        logic                       wr;
        logic [`VTP_PA_WIDTH-1:0]   addr;
        logic [`VTP_DATA_WIDTH-1:0] data;
    } mem_req_t;

    // One page table entry, an invalid entry always misses
    typedef struct packed {
        logic             valid;
        logic [ppn_w-1:0] ppn;
    } pt_entry_t;

    // Lookup carries the full page number so range errors can be detected
    typedef struct packed {
        logic [vpn_w-1:0] vpn;
    } pt_lookup_t;

endpackage

// ==== rtl/vtp_rr_arbiter.sv ====
/*
 * Round-robin merge of strobed payloads with a one-deep slot per source.
 * A source may not strobe again until its previous payload has been granted.
 */
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_rr_arbiter
    import vtp_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`VTP_NUM_SOURCES-1:0]   in_valid,
    input  payload_t                      in_payload [`VTP_NUM_SOURCES],
    output logic                          grant_valid,
    output src_id_t                       grant_src,
    output payload_t                      grant_payload
);

    logic [`VTP_NUM_SOURCES-1:0] slot_full_q;
    payload_t                    slot_q [`VTP_NUM_SOURCES];
    src_id_t                     ptr_q;
    logic [`VTP_NUM_SOURCES-1:0] pending;
    payload_t                    pend_payload [`VTP_NUM_SOURCES];
    logic                        found;
    src_id_t                     win_src;

    // A fresh strobe competes in the same cycle, so an idle arbiter
    // grants it straight from the input without waiting in the slot
    always_comb begin
        for (int i = 0; i < `VTP_NUM_SOURCES; i++) begin
            pending[i]      = slot_full_q[i] || in_valid[i];
            pend_payload[i] = slot_full_q[i] ? slot_q[i] : in_payload[i];
        end
    end

    // Search starts at the source after the last winner
    always_comb begin
        src_id_t cand;
        found   = 1'b0;
        win_src = '0;
        for (int k = 0; k < `VTP_NUM_SOURCES; k++) begin
            cand = src_id_t'((int'(ptr_q) + k) % `VTP_NUM_SOURCES);
            if (!found && pending[cand]) begin
                found   = 1'b1;
                win_src = cand;
            end
        end
    end

    // ==================================================================
    // Slots, pointer and registered grant
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full_q <= '0;
            ptr_q       <= '0;
            grant_valid <= 1'b0;
        end else begin
            grant_valid <= found;
            if (found) begin
                ptr_q <= src_id_t'((int'(win_src) + 1) % `VTP_NUM_SOURCES);
            end
            for (int i = 0; i < `VTP_NUM_SOURCES; i++) begin
                // Winner's slot empties unless a new strobe refills it
                if (found && win_src == src_id_t'(i)) begin
                    slot_full_q[i] <= slot_full_q[i] && in_valid[i];
                end else begin
                    slot_full_q[i] <= pending[i];
                end
            end
        end
    end

    // Slot payload is held only while slot_full_q says so
    always_ff @(posedge clk) begin
        for (int i = 0; i < `VTP_NUM_SOURCES; i++) begin
            if (in_valid[i] && !(found && win_src == src_id_t'(i) && !slot_full_q[i])) begin
                slot_q[i] <= in_payload[i];
            end
        end
        grant_src     <= win_src;
        grant_payload <= pend_payload[win_src];
    end

    // Relies on the source's busy level keeping one payload in flight
    for (genvar g = 0; g < `VTP_NUM_SOURCES; g++) begin : g_chk
        a_no_slot_overrun: assert property (@(posedge clk) disable iff (!rst_n)
            (in_valid[g] && slot_full_q[g]) |-> (found && win_src == src_id_t'(g)));
    end

endmodule

// ==== rtl/vtp_translate.sv ====
/*
 * Translator for one source, holding a single request at a time.
 * The source must keep req_valid low while busy is high.
 */
`timescale 1ns/1ns
`include "vtp_settings.svh"

module vtp_translate
    import vtp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  va_req_t    req,
    output logic       busy,
    output logic       lookup_valid,
    output pt_lookup_t lookup,
    input  logic       rsp_valid,
    input  pt_entry_t  rsp_entry,
    input  logic       rsp_hit,
    output logic       out_valid,
    output mem_req_t   out_req,
    output logic       err
);

    // Emit lasts one cycle with busy already low, so the
    // source can hand over its next request right away
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_emit
    } state_t;

    state_t           state_q;
    logic             accept;
    va_req_t          req_q;
    logic [ppn_w-1:0] ppn_q;
    logic             hit_q;

    assign accept = req_valid && (state_q != st_wait);

    // ==================================================================
    // Controller
    // ==================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= st_idle;
            lookup_valid <= 1'b0;
        end else begin
            // Lookup goes out in the first cycle of the wait
            lookup_valid <= accept;
            case (state_q)
                st_wait: begin
                    if (rsp_valid) begin
                        state_q <= st_emit;
                    end
                end
                default: begin
                    state_q <= accept ? st_wait : st_idle;
                end
            endcase
        end
    end

    // Request and lookup result are payload, qualified by the state
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (state_q == st_wait && rsp_valid) begin
            ppn_q <= rsp_entry.ppn;
            hit_q <= rsp_hit;
        end
    end

    // ==================================================================
    // Outputs
    // ==================================================================

    assign busy       = (state_q == st_wait);
    assign lookup.vpn = req_q.addr[`VTP_VA_WIDTH-1:`VTP_PAGE_BITS];

    // Physical page from the table, offset passed through as sent
    assign out_req.wr   = req_q.wr;
    assign out_req.addr = {ppn_q, req_q.addr[`VTP_PAGE_BITS-1:0]};
    assign out_req.data = req_q.data;

    assign out_valid = (state_q == st_emit) && hit_q;
    assign err       = (state_q == st_emit) && !hit_q;

    // The source side owns this rule, the translator only checks it
    a_no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !busy);

endmodule

// ==== verilog.f ====
+incdir+include
rtl/vtp_pkg.sv
rtl/vtp_page_table.sv
rtl/vtp_rr_arbiter.sv
rtl/vtp_translate.sv
rtl/host_mem_vtp.sv
dv/host_mem_vtp_tb.sv
